// File: src.f
hdl/radio_ctrl_pkg.sv
hdl/board_ctrl_regs.sv
hdl/vita_time.sv
hdl/event_timer.sv
hdl/radio_ctrl_top.sv
test/tb_clk_gen.sv
test/radio_ctrl_properties.sv
test/radio_ctrl_tb.sv

// File: Makefile
# Verilator build and run of the radio control testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -f src.f --top-module radio_ctrl_tb \
		-Mdir obj_dir -o radio_ctrl_sim
	./obj_dir/radio_ctrl_sim | tee $(LOG)
	grep -q "^TESTS PASSED$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: test/radio_ctrl_tb.sv
//////////////////////////////
// Table driven testbench for the
// radio board control top level
//////////////////////////////
`timescale 1ns/100ps

module radio_ctrl_tb;

   localparam logic [31:0] TICKS       = 32'd50;
   localparam int          RST_TIMEOUT = 20;

   // What an entry looks at when its window closes
   typedef enum int {
      PROBE_NONE,
      PROBE_CTRL,
      PROBE_LEDS,
      PROBE_TIME,
      PROBE_PPS_CNT,
      PROBE_ONE_SHOT,
      PROBE_PER_CNT
   } probe_e;

   typedef struct {
      string                       name;
      logic                        wr;
      radio_ctrl_pkg::sr_addr_t    addr;
      radio_ctrl_pkg::sr_data_t    data;
      radio_ctrl_pkg::led_status_t led;
      logic                        pps;
      int                          wait_cycles;
      probe_e                      probe;
      logic [63:0]                 expected;
   } entry_t;

   logic                        dsp_clk;
   logic                        wb_rst;
   radio_ctrl_pkg::set_bus_t    set_bus;
   logic                        pps;
   radio_ctrl_pkg::led_status_t led_status;
   radio_ctrl_pkg::board_ctrl_t board_ctrl;
   logic [7:0]                  leds;
   radio_ctrl_pkg::vita_time_t  vita_time;
   logic                        pps_int;
   logic                        onetime_int;
   logic                        periodic_int;

   entry_t                      table_q[$];
   logic [31:0]                 rand_state = 32'hd339;
   radio_ctrl_pkg::led_status_t cur_led;
   logic                        cur_pps;
   logic [31:0]                 ref_secs;
   logic [31:0]                 ref_ticks;
   int                          time_pos;
   int                          checks;
   int                          errors;
   int                          rst_wait;

   tb_clk_gen i_clk_gen (
      .dsp_clk_o (dsp_clk),
      .wb_rst_o  (wb_rst)
   );

   radio_ctrl_top #(
      .TICKS_PER_SEC (TICKS)
   ) i_dut (
      .dsp_clk        (dsp_clk),
      .wb_rst         (wb_rst),
      .set_i          (set_bus),
      .pps_i          (pps),
      .led_status_i   (led_status),
      .board_ctrl_o   (board_ctrl),
      .leds_o         (leds),
      .vita_time_o    (vita_time),
      .pps_int_o      (pps_int),
      .onetime_int_o  (onetime_int),
      .periodic_int_o (periodic_int)
   );

   bind radio_ctrl_top radio_ctrl_properties #(
      .TICKS_PER_SEC (TICKS_PER_SEC)
   ) i_properties (
      .dsp_clk_i      (dsp_clk),
      .wb_rst_i       (wb_rst),
      .board_ctrl_i   (board_ctrl_o),
      .vita_time_i    (vita_time_o),
      .pps_int_i      (pps_int_o),
      .onetime_int_i  (onetime_int_o),
      .periodic_int_i (periodic_int_o)
   );

   //////////////////////////////
   // Reference helpers
   //////////////////////////////
   function automatic logic [31:0] lcg_next();
      rand_state = rand_state * 32'd1664525 + 32'd1013904223;
      return rand_state;
   endfunction

   // Stamp reached a number of edges after a known stamp
   // Ticks wrap at TICKS
   function automatic logic [63:0] time_after(logic [31:0] secs, logic [31:0] ticks,
                                              int edges);
      logic [31:0] total;
      total = ticks + 32'(edges);
      return {secs + total / TICKS, total % TICKS};
   endfunction

   // Each entry spends a drive edge, a capture edge and its wait
   task automatic add_entry(string name, logic wr, radio_ctrl_pkg::sr_addr_t addr,
                            radio_ctrl_pkg::sr_data_t data, int wait_cycles,
                            probe_e probe, logic [63:0] expected);
      entry_t e;
      e.name        = name;
      e.wr          = wr;
      e.addr        = addr;
      e.data        = data;
      e.led         = cur_led;
      e.pps         = cur_pps;
      e.wait_cycles = wait_cycles;
      e.probe       = probe;
      e.expected    = expected;
      table_q.push_back(e);
      time_pos = time_pos + 2 + wait_cycles;
   endtask

   task automatic compare(string name, logic [63:0] expected, logic [63:0] actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
      end else begin
         $display("ok %s %h", name, actual);
      end
   endtask

   //////////////////////////////
   // Stimulus table
   //////////////////////////////
   task automatic build_table();
      radio_ctrl_pkg::board_ctrl_t exp_ctrl;
      radio_ctrl_pkg::led_status_t led;
      logic [31:0]                 r;
      logic [7:0]                  sw;
      logic [7:0]                  src;
      logic [7:0]                  hw;
      logic [7:0]                  exp_leds;
      int                          i;
      int                          b;

      exp_ctrl             = '0;
      exp_ctrl.phy_reset_n = 1'b1;
      cur_led              = '1;
      cur_pps              = 1'b0;
      time_pos             = 0;
      add_entry("reset_ctrl", 1'b0, '0, '0, 0, PROBE_CTRL, 64'(exp_ctrl));
      add_entry("reset_leds", 1'b0, '0, '0, 0, PROBE_LEDS, 64'h1e);

      for (i = 0; i < 2; i++) begin
         r = lcg_next();
         exp_ctrl.clock_ready = r[4];
         exp_ctrl.clk_en      = r[3:2];
         exp_ctrl.clk_sel     = r[1:0];
         add_entry($sformatf("ctrl_clock_%0d", i), 1'b1, radio_ctrl_pkg::SR_CLOCK, r, 0,
                   PROBE_CTRL, 64'(exp_ctrl));
         r = lcg_next();
         exp_ctrl.ser_enable = r[3];
         exp_ctrl.ser_prbsen = r[2];
         exp_ctrl.ser_loopen = r[1];
         exp_ctrl.ser_rx_en  = r[0];
         add_entry($sformatf("ctrl_serdes_%0d", i), 1'b1, radio_ctrl_pkg::SR_SERDES, r, 0,
                   PROBE_CTRL, 64'(exp_ctrl));
         r = lcg_next();
         exp_ctrl.adc_oe_a = r[3];
         exp_ctrl.adc_on_a = r[2];
         exp_ctrl.adc_oe_b = r[1];
         exp_ctrl.adc_on_b = r[0];
         add_entry($sformatf("ctrl_adc_%0d", i), 1'b1, radio_ctrl_pkg::SR_ADC, r, 0,
                   PROBE_CTRL, 64'(exp_ctrl));
         r = lcg_next();
         exp_ctrl.phy_reset_n = ~r[0];
         add_entry($sformatf("ctrl_phy_%0d", i), 1'b1, radio_ctrl_pkg::SR_PHY, r, 0,
                   PROBE_CTRL, 64'(exp_ctrl));
      end

      // Mask bit set takes the hardware source for that LED
      for (i = 0; i < 3; i++) begin
         r   = lcg_next();
         sw  = r[7:0];
         add_entry($sformatf("led_sw_%0d", i), 1'b1, radio_ctrl_pkg::SR_LED_SW, r, 0,
                   PROBE_NONE, '0);
         r   = lcg_next();
         src = r[7:0];
         r   = lcg_next();
         led = r[3:0];
         hw    = 8'h00;
         hw[4] = led.run_tx;
         hw[3] = led.run_rx;
         hw[2] = led.clk_status;
         hw[1] = led.link_up;
         for (b = 0; b < 8; b++)
            exp_leds[b] = src[b] ? hw[b] : sw[b];
         cur_led = led;
         add_entry($sformatf("led_select_%0d", i), 1'b1, radio_ctrl_pkg::SR_LED_SRC,
                   {24'h0, src}, 0, PROBE_LEDS, 64'(exp_leds));
      end

      //////////////////////////////
      // Time loads
      //////////////////////////////
      add_entry("time_pend_secs", 1'b1, radio_ctrl_pkg::SR_TIME64, 32'd7, 0, PROBE_NONE, '0);
      add_entry("time_pend_ticks", 1'b1, radio_ctrl_pkg::SR_TIME64 + 8'd1, 32'd45, 0,
                PROBE_NONE, '0);
      ref_secs  = 32'd7;
      ref_ticks = 32'd45;
      add_entry("time_load_now", 1'b1, radio_ctrl_pkg::SR_TIME64 + 8'd2, 32'd1, 10,
                PROBE_TIME, time_after(ref_secs, ref_ticks, 10));
      time_pos = 10;
      add_entry("time_rollover", 1'b0, '0, '0, 60, PROBE_TIME,
                time_after(ref_secs, ref_ticks, time_pos + 62));

      add_entry("time_arm_secs", 1'b1, radio_ctrl_pkg::SR_TIME64, 32'd100, 0, PROBE_NONE, '0);
      add_entry("time_arm_ticks", 1'b1, radio_ctrl_pkg::SR_TIME64 + 8'd1, 32'd3, 0,
                PROBE_NONE, '0);
      // Count runs on untouched while armed
      add_entry("time_armed_hold", 1'b1, radio_ctrl_pkg::SR_TIME64 + 8'd2, 32'd0, 6,
                PROBE_TIME, time_after(ref_secs, ref_ticks, time_pos + 8));
      // Rise seen on the second edge after the drive edge
      cur_pps = 1'b1;
      add_entry("pps_int_pulses", 1'b0, '0, '0, 4, PROBE_PPS_CNT, 64'd1);
      ref_secs  = 32'd100;
      ref_ticks = 32'd3;
      time_pos  = 3;
      cur_pps   = 1'b0;
      add_entry("time_pps_load", 1'b0, '0, '0, 5, PROBE_TIME,
                time_after(ref_secs, ref_ticks, time_pos + 7));

      //////////////////////////////
      // Timers
      //////////////////////////////
      // One-shot result is {pulse count, first pulse edge}
      add_entry("oneshot_d12", 1'b1, radio_ctrl_pkg::SR_SIMTIMER, 32'd12, 20,
                PROBE_ONE_SHOT, {32'd1, 32'd12});
      add_entry("oneshot_arm", 1'b1, radio_ctrl_pkg::SR_SIMTIMER, 32'd5, 0, PROBE_NONE, '0);
      add_entry("oneshot_cancel", 1'b1, radio_ctrl_pkg::SR_SIMTIMER, 32'd0, 10,
                PROBE_ONE_SHOT, {32'd0, 32'hffff_ffff});
      add_entry("periodic_p7", 1'b1, radio_ctrl_pkg::SR_SIMTIMER + 8'd1, 32'd7, 35,
                PROBE_PER_CNT, 64'd5);
      add_entry("periodic_off", 1'b1, radio_ctrl_pkg::SR_SIMTIMER + 8'd1, 32'd0, 21,
                PROBE_PER_CNT, 64'd0);
   endtask

   //////////////////////////////
   // Apply one entry
   //////////////////////////////
   task automatic apply_entry(entry_t e);
      int          one_cnt;
      int          one_first;
      int          per_cnt;
      int          pps_cnt;
      int          i;
      logic [63:0] actual;

      one_cnt   = 0;
      one_first = -1;
      per_cnt   = 0;
      pps_cnt   = 0;
      @(posedge dsp_clk);
      set_bus.stb  <= e.wr;
      set_bus.addr <= e.addr;
      set_bus.data <= e.data;
      led_status   <= e.led;
      pps          <= e.pps;
      // Capture edge
      @(posedge dsp_clk);
      set_bus.stb <= 1'b0;
      for (i = 0; i <= e.wait_cycles; i++) begin
         if (i > 0)
            @(posedge dsp_clk);
         @(negedge dsp_clk);
         if (onetime_int === 1'b1) begin
            if (one_cnt == 0)
               one_first = i;
            one_cnt++;
         end
         if (periodic_int === 1'b1)
            per_cnt++;
         if (pps_int === 1'b1)
            pps_cnt++;
      end
      case (e.probe)
         PROBE_CTRL:     actual = 64'(board_ctrl);
         PROBE_LEDS:     actual = 64'(leds);
         PROBE_TIME:     actual = vita_time;
         PROBE_PPS_CNT:  actual = 64'(pps_cnt);
         PROBE_ONE_SHOT: actual = {32'(one_cnt), 32'(one_first)};
         PROBE_PER_CNT:  actual = 64'(per_cnt);
         default:        actual = '0;
      endcase
      if (e.probe != PROBE_NONE)
         compare(e.name, e.expected, actual);
   endtask

   initial begin
      set_bus    <= '0;
      pps        <= 1'b0;
      led_status <= '1;
      checks   = 0;
      errors   = 0;
      rst_wait = 0;
      build_table();
      // Reset is only looked at on falling edges
      do begin
         @(negedge dsp_clk);
         rst_wait++;
      end while (wb_rst !== 1'b0 && rst_wait < RST_TIMEOUT);
      if (wb_rst !== 1'b0) begin
         $display("ERROR: reset still asserted after %0d cycles", RST_TIMEOUT);
         $display("TESTS FAILED");
         $finish;
      end else begin
         foreach (table_q[n])
            apply_entry(table_q[n]);
         $display("%0d checks, %0d passed, %0d failed", checks, checks - errors, errors);
         if (errors == 0) begin
            $display("TESTS PASSED");
         end else begin
            $display("TESTS FAILED");
         end
         $finish;
      end
   end

endmodule

// File: test/radio_ctrl_properties.sv
//////////////////////////////
// Concurrent checks on the radio
// control top level outputs
//////////////////////////////
`timescale 1ns/100ps

module radio_ctrl_properties #(
   parameter logic [31:0] TICKS_PER_SEC = 32'd100_000_000
) (
   input logic                        dsp_clk_i,
   input logic                        wb_rst_i,
   input radio_ctrl_pkg::board_ctrl_t board_ctrl_i,
   input radio_ctrl_pkg::vita_time_t  vita_time_i,
   input logic                        pps_int_i,
   input logic                        onetime_int_i,
   input logic                        periodic_int_i
);

   // Interrupts are single cycle pulses
   pps_int_pulse: assert property (@(posedge dsp_clk_i) disable iff (wb_rst_i)
      pps_int_i |=> !pps_int_i)
      else $error("pps_int_o held high for two cycles");

   onetime_int_pulse: assert property (@(posedge dsp_clk_i) disable iff (wb_rst_i)
      onetime_int_i |=> !onetime_int_i)
      else $error("onetime_int_o held high for two cycles");

   periodic_int_pulse: assert property (@(posedge dsp_clk_i) disable iff (wb_rst_i)
      periodic_int_i |=> !periodic_int_i)
      else $error("periodic_int_o held high for two cycles");

   // PHY leaves reset released
   phy_out_of_reset: assert property (@(posedge dsp_clk_i)
      wb_rst_i |=> board_ctrl_i.phy_reset_n)
      else $error("phy_reset_n low in the cycle after reset");

   ticks_in_range: assert property (@(posedge dsp_clk_i) disable iff (wb_rst_i)
      vita_time_i[31:0] < TICKS_PER_SEC)
      else $error("vita time ticks reached TICKS_PER_SEC");

endmodule

// File: test/tb_clk_gen.sv
//////////////////////////////
// Testbench clock and reset
//////////////////////////////
`timescale 1ns/100ps

module tb_clk_gen #(
   parameter int HALF_PERIOD_NS = 5,
   parameter int RESET_CYCLES   = 3
) (
   output logic dsp_clk_o,
   output logic wb_rst_o
);

   initial begin
      dsp_clk_o = 1'b0;
      forever #(HALF_PERIOD_NS) dsp_clk_o = ~dsp_clk_o;
   end

   // Reset released on a rising edge
   initial begin
      wb_rst_o <= 1'b1;
      repeat (RESET_CYCLES) @(posedge dsp_clk_o);
      wb_rst_o <= 1'b0;
   end

endmodule

// File: hdl/radio_ctrl_top.sv
//////////////////////////////
// Radio board control top level
//////////////////////////////
`timescale 1ns/100ps

module radio_ctrl_top #(
   parameter logic [31:0] TICKS_PER_SEC = 32'd100_000_000
) (
   input  logic                        dsp_clk,
   input  logic                        wb_rst,
   input  radio_ctrl_pkg::set_bus_t    set_i,
   input  logic                        pps_i,
   input  radio_ctrl_pkg::led_status_t led_status_i,
   output radio_ctrl_pkg::board_ctrl_t board_ctrl_o,
   output logic [7:0]                  leds_o,
   output radio_ctrl_pkg::vita_time_t  vita_time_o,
   output logic                        pps_int_o,
   output logic                        onetime_int_o,
   output logic                        periodic_int_o
);

   // Every block sees the full settings bus and decodes its own range

   // Clock, SERDES, ADC, PHY lines and LEDs
   board_ctrl_regs i_board_ctrl_regs (
      .dsp_clk      (dsp_clk),
      .wb_rst       (wb_rst),
      .set_i        (set_i),
      .led_status_i (led_status_i),
      .board_ctrl_o (board_ctrl_o),
      .leds_o       (leds_o)
   );

   // 64 bit VITA time with PPS
   vita_time #(
      .TICKS_PER_SEC (TICKS_PER_SEC)
   ) i_vita_time (
      .dsp_clk     (dsp_clk),
      .wb_rst      (wb_rst),
      .set_i       (set_i),
      .pps_i       (pps_i),
      .vita_time_o (vita_time_o),
      .pps_int_o   (pps_int_o)
   );

   // One-shot and periodic interrupts
   event_timer i_event_timer (
      .dsp_clk        (dsp_clk),
      .wb_rst         (wb_rst),
      .set_i          (set_i),
      .onetime_int_o  (onetime_int_o),
      .periodic_int_o (periodic_int_o)
   );

endmodule

// File: hdl/event_timer.sv
//////////////////////////////
// One-shot and periodic interrupt timers
//////////////////////////////
`timescale 1ns/100ps

module event_timer (
   input  logic                     dsp_clk,
   input  logic                     wb_rst,
   input  radio_ctrl_pkg::set_bus_t set_i,
   output logic                     onetime_int_o,
   output logic                     periodic_int_o
);

   localparam radio_ctrl_pkg::sr_addr_t ADDR_ONESHOT = radio_ctrl_pkg::SR_SIMTIMER;
   localparam radio_ctrl_pkg::sr_addr_t ADDR_PERIOD  = radio_ctrl_pkg::SR_SIMTIMER + 8'd1;

   radio_ctrl_pkg::sr_data_t oneshot_cnt_q;
   radio_ctrl_pkg::sr_data_t period_q;
   radio_ctrl_pkg::sr_data_t period_cnt_q;
   logic                     oneshot_int_q;
   logic                     periodic_int_q;
   logic                     oneshot_wr;
   logic                     period_wr;

   assign oneshot_wr = set_i.stb && (set_i.addr == ADDR_ONESHOT);
   assign period_wr  = set_i.stb && (set_i.addr == ADDR_PERIOD);

   //////////////////////////////
   // One-shot down-counter
   //////////////////////////////
   // Fires on the edge where the count leaves 1, zero means idle
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         oneshot_cnt_q <= '0;
         oneshot_int_q <= 1'b0;
      end else if (oneshot_wr) begin
         oneshot_cnt_q <= set_i.data;
         oneshot_int_q <= 1'b0;
      end else begin
         oneshot_int_q <= (oneshot_cnt_q == 32'd1);
         if (oneshot_cnt_q != '0)
            oneshot_cnt_q <= oneshot_cnt_q - 32'd1;
      end
   end

   //////////////////////////////
   // Periodic reloading counter
   //////////////////////////////
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         period_q       <= '0;
         period_cnt_q   <= '0;
         periodic_int_q <= 1'b0;
      end else if (period_wr) begin
         period_q       <= set_i.data;
         period_cnt_q   <= set_i.data;
         periodic_int_q <= 1'b0;
      end else if (period_q == '0) begin
         periodic_int_q <= 1'b0;
      end else if (period_cnt_q == 32'd1) begin
         period_cnt_q   <= period_q;
         periodic_int_q <= 1'b1;
      end else begin
         period_cnt_q   <= period_cnt_q - 32'd1;
         periodic_int_q <= 1'b0;
      end
   end

   assign onetime_int_o  = oneshot_int_q;
   assign periodic_int_o = periodic_int_q;

endmodule

// File: hdl/vita_time.sv
//////////////////////////////
// VITA seconds and ticks counter
// with PPS detection and timed load
//////////////////////////////
`timescale 1ns/100ps

module vita_time #(
   parameter logic [31:0] TICKS_PER_SEC = 32'd100_000_000
) (
   input  logic                       dsp_clk,
   input  logic                       wb_rst,
   input  radio_ctrl_pkg::set_bus_t   set_i,
   input  logic                       pps_i,
   output radio_ctrl_pkg::vita_time_t vita_time_o,
   output logic                       pps_int_o
);

   localparam radio_ctrl_pkg::sr_addr_t ADDR_SECS  = radio_ctrl_pkg::SR_TIME64;
   localparam radio_ctrl_pkg::sr_addr_t ADDR_TICKS = radio_ctrl_pkg::SR_TIME64 + 8'd1;
   localparam radio_ctrl_pkg::sr_addr_t ADDR_LOAD  = radio_ctrl_pkg::SR_TIME64 + 8'd2;
   localparam radio_ctrl_pkg::sr_data_t TICK_LAST  = TICKS_PER_SEC - 32'd1;

   radio_ctrl_pkg::sr_data_t   pend_secs_q;
   radio_ctrl_pkg::sr_data_t   pend_ticks_q;
   radio_ctrl_pkg::sr_data_t   secs_q;
   radio_ctrl_pkg::sr_data_t   ticks_q;
   radio_ctrl_pkg::time_load_e state_q;
   logic                       pps_d1_q;
   logic                       pps_d2_q;
   logic                       pps_rise;
   logic                       pps_int_q;
   logic                       load_wr;
   logic                       load_now;
   logic                       load_pps;

   //////////////////////////////
   // Pending time registers
   //////////////////////////////
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         pend_secs_q  <= '0;
         pend_ticks_q <= '0;
      end else if (set_i.stb) begin
         if (set_i.addr == ADDR_SECS)
            pend_secs_q <= set_i.data;
         if (set_i.addr == ADDR_TICKS)
            pend_ticks_q <= set_i.data;
      end
   end

   // Commit write, bit 0 set means load right away
   assign load_wr  = set_i.stb && (set_i.addr == ADDR_LOAD);
   assign load_now = load_wr && set_i.data[0];

   //////////////////////////////
   // PPS edge detect
   //////////////////////////////
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         pps_d1_q  <= 1'b0;
         pps_d2_q  <= 1'b0;
         pps_int_q <= 1'b0;
      end else begin
         pps_d1_q  <= pps_i;
         pps_d2_q  <= pps_d1_q;
         pps_int_q <= pps_rise;
      end
   end

   assign pps_rise = pps_d1_q & ~pps_d2_q;

   // A fresh commit on the same edge wins over the armed load
   assign load_pps = (state_q == radio_ctrl_pkg::TIME_ARMED) && pps_rise && !load_wr;

   //////////////////////////////
   // Load FSM
   //////////////////////////////
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         state_q <= radio_ctrl_pkg::TIME_IDLE;
      end else begin
         case (state_q)
            radio_ctrl_pkg::TIME_IDLE: begin
               if (load_wr && !set_i.data[0])
                  state_q <= radio_ctrl_pkg::TIME_ARMED;
            end
            radio_ctrl_pkg::TIME_ARMED: begin
               if (load_now || load_pps)
                  state_q <= radio_ctrl_pkg::TIME_IDLE;
            end
            default: state_q <= radio_ctrl_pkg::TIME_IDLE;
         endcase
      end
   end

   //////////////////////////////
   // Seconds and ticks counter
   //////////////////////////////
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         secs_q  <= '0;
         ticks_q <= '0;
      end else if (load_now || load_pps) begin
         // Load replaces this edge's increment
         secs_q  <= pend_secs_q;
         ticks_q <= pend_ticks_q;
      end else if (ticks_q == TICK_LAST) begin
         secs_q  <= secs_q + 32'd1;
         ticks_q <= '0;
      end else begin
         ticks_q <= ticks_q + 32'd1;
      end
   end

   assign vita_time_o = {secs_q, ticks_q};
   assign pps_int_o   = pps_int_q;

endmodule

// File: hdl/board_ctrl_regs.sv
//////////////////////////////
// Board control settings registers
// and the per-bit LED source selector
//////////////////////////////
`timescale 1ns/100ps

module board_ctrl_regs (
   input  logic                        dsp_clk,
   input  logic                        wb_rst,
   input  radio_ctrl_pkg::set_bus_t    set_i,
   input  radio_ctrl_pkg::led_status_t led_status_i,
   output radio_ctrl_pkg::board_ctrl_t board_ctrl_o,
   output logic [7:0]                  leds_o
);

   logic [4:0] clock_q;
   logic [3:0] serdes_q;
   logic [3:0] adc_q;
   logic       phy_reset_q;
   logic [7:0] led_sw_q;
   logic [7:0] led_src_q;
   logic [7:0] led_hw;

   //////////////////////////////
   // Settings registers
   //////////////////////////////
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         clock_q     <= '0;
         serdes_q    <= '0;
         adc_q       <= '0;
         phy_reset_q <= 1'b0;
         led_sw_q    <= '0;
         led_src_q   <= radio_ctrl_pkg::LED_SRC_RESET;
      end else if (set_i.stb) begin
         // Only the low bits of each word are kept
         case (set_i.addr)
            radio_ctrl_pkg::SR_CLOCK:   clock_q     <= set_i.data[4:0];
            radio_ctrl_pkg::SR_SERDES:  serdes_q    <= set_i.data[3:0];
            radio_ctrl_pkg::SR_ADC:     adc_q       <= set_i.data[3:0];
            radio_ctrl_pkg::SR_PHY:     phy_reset_q <= set_i.data[0];
            radio_ctrl_pkg::SR_LED_SW:  led_sw_q    <= set_i.data[7:0];
            radio_ctrl_pkg::SR_LED_SRC: led_src_q   <= set_i.data[7:0];
            default: ;
         endcase
      end
   end

   //////////////////////////////
   // Control line fields
   //////////////////////////////
   assign {board_ctrl_o.clock_ready,
           board_ctrl_o.clk_en,
           board_ctrl_o.clk_sel} = clock_q;

   assign {board_ctrl_o.ser_enable,
           board_ctrl_o.ser_prbsen,
           board_ctrl_o.ser_loopen,
           board_ctrl_o.ser_rx_en} = serdes_q;

   assign {board_ctrl_o.adc_oe_a,
           board_ctrl_o.adc_on_a,
           board_ctrl_o.adc_oe_b,
           board_ctrl_o.adc_on_b} = adc_q;

   // PHY reset pin is active low
   assign board_ctrl_o.phy_reset_n = ~phy_reset_q;

   //////////////////////////////
   // LED selector
   //////////////////////////////
   // Hardware sources sit on bits 4..1
   assign led_hw = {3'b000, led_status_i, 1'b0};

   // Mask bit 1 picks hardware, 0 picks software
   assign leds_o = (led_src_q & led_hw) | (~led_src_q & led_sw_q);

endmodule

// File: hdl/radio_ctrl_pkg.sv
//////////////////////////////
// Radio control register map, bus types
// and the time load state encoding
//////////////////////////////

package radio_ctrl_pkg;

   //////////////////////////////
   // Bus and time widths
   //////////////////////////////
   typedef logic [7:0]  sr_addr_t;
   typedef logic [31:0] sr_data_t;
   // Seconds in the upper word, ticks in the lower word
   typedef logic [63:0] vita_time_t;

   // One settings write, no handshake
   typedef struct packed {
      logic     stb;
      sr_addr_t addr;
      sr_data_t data;
   } set_bus_t;

   // Board control lines
   typedef struct packed {
      logic       clock_ready;
      logic [1:0] clk_en;
      logic [1:0] clk_sel;
      logic       ser_enable;
      logic       ser_prbsen;
      logic       ser_loopen;
      logic       ser_rx_en;
      logic       adc_oe_a;
      logic       adc_on_a;
      logic       adc_oe_b;
      logic       adc_on_b;
      logic       phy_reset_n;
   } board_ctrl_t;

   // Hardware LED sources, msb first as they land on leds[4:1]
   typedef struct packed {
      logic run_tx;
      logic run_rx;
      logic clk_status;
      logic link_up;
   } led_status_t;

   //////////////////////////////
   // Settings register map
   //////////////////////////////
   localparam sr_addr_t SR_CLOCK    = 8'd0;
   localparam sr_addr_t SR_SERDES   = 8'd1;
   localparam sr_addr_t SR_ADC      = 8'd2;
   localparam sr_addr_t SR_LED_SW   = 8'd3;
   localparam sr_addr_t SR_PHY      = 8'd4;
   localparam sr_addr_t SR_LED_SRC  = 8'd8;
   // Three registers from here
   localparam sr_addr_t SR_TIME64   = 8'd192;
   // Two registers from here
   localparam sr_addr_t SR_SIMTIMER = 8'd198;

   // LEDs 4..1 follow hardware out of reset
   localparam logic [7:0] LED_SRC_RESET = 8'h1e;

   // Time load FSM
   typedef enum logic {
      TIME_IDLE,
      TIME_ARMED
   } time_load_e;

endpackage
